// ==== hdl/main_bus_pkg.sv ====
/*
 * Shared definitions for the main CPU memory and I/O block
 * Bus, ROM address and data widths
 * Write and read offsets inside the cabinet I/O page
 * Chip-select struct, decoded request and response payloads
 */
package main_bus_pkg;

    // 8 bank bits above the 16-bit CPU address
    localparam int addr_w     = 24;
    localparam int rom_addr_w = 18;
    localparam int data_w     = 8;

    // I/O page, write side
    localparam logic [3:0] io_ctrl_ofs = 4'd8;
    localparam logic [3:0] io_snd_ofs  = 4'd12;

    // I/O page, read side
    localparam logic [3:0] io_dip_hi_ofs  = 4'd0;
    localparam logic [3:0] io_p1_ofs      = 4'd1;
    localparam logic [3:0] io_p2_ofs      = 4'd2;
    localparam logic [3:0] io_dip_mid_ofs = 4'd3;
    localparam logic [3:0] io_dip_lo_ofs  = 4'd4;

    // Decoder result, one bit per device
    typedef struct packed {
        logic rom;
        logic banked;
        logic ram;
        logic io;
        logic pal;
        logic tile;
        logic obj;
    } bus_sel_t;

    // Stage 1 payload
    typedef struct packed {
        bus_sel_t              sel;
        logic [3:0]            ofs;
        logic                  we;
        logic [data_w-1:0]     wdata;
        logic [rom_addr_w-1:0] rom_addr;
    } bus_req_t;

    // Stage 2 payload, travels with ack
    typedef struct packed {
        logic [data_w-1:0] rdata;
        logic              we;
    } bus_rsp_t;

endpackage

// ==== hdl/pipe_stage.sv ====
/*
 * Pipeline register for the main CPU bus
 * Valid flag with asynchronous clear
 * Payload of any packed type, held while stalled
 */
`timescale 1ns/1ns

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    input  logic     stall,
    output logic     out_valid,
    output payload_t out_data
);

    // Valid flag, frozen during a stall
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= in_valid;
        end
    end

    // Payload only follows a valid input
    // keeps the last beat around for debug
    always_ff @(posedge clk) begin
        if (!stall && in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

// ==== hdl/addr_decode.sv ====
/*
 * Stage 1 address decoder
 * CPU address to chip selects for ROM, RAM, palette,
 * tile, object and the cabinet I/O page
 * ROM address for the fixed and banked windows
 * Packs the decoded request for the stage 1 register
 */
`timescale 1ns/1ns

module addr_decode (
    input  logic [main_bus_pkg::addr_w-1:0] addr,
    input  logic                            we,
    input  logic [main_bus_pkg::data_w-1:0] dout,
    input  logic                            work,
    input  logic                            rmrd,
    input  logic                            init,
    output main_bus_pkg::bus_req_t          req_data
);
    import main_bus_pkg::*;

    logic [4:0]  bank;
    logic [15:0] a;
    bus_sel_t    sel;

    // Only 5 bank bits reach the ROM
    assign bank = addr[20:16];
    assign a    = addr[15:0];

    always_comb begin
        // 2000-3FFF banked window
        sel.banked = a[15:13] == 3'd1;
        // Fixed program ROM from 8000 up
        sel.rom    = a[15] || sel.banked;
        // Low 1kB is shared with the palette
        sel.ram    = a[15:13] == 3'd0 && (|a[12:10] || !work);
        // 5F80-5F9F
        sel.io     = a[15:7] == 9'h0bf && a[6:5] == 2'd0;
        sel.pal    = a[15:10] == 6'd0 && work;
        // Object RAM and its registers at 7800
        sel.obj    = a[15:11] == 5'h0f && !rmrd && init &&
                     (a[10] || a[9:3] == 7'd0);
        // Whatever is left of 4000-7FFF
        sel.tile   = a[15:14] == 2'd1 && !sel.io && !sel.pal && !sel.obj;
    end

    always_comb begin
        req_data.sel   = sel;
        // Register offset within the I/O page
        req_data.ofs   = a[3:0];
        req_data.we    = we;
        req_data.wdata = dout;
        // 5+13 bits banked, 2+16 bits fixed
        if (sel.banked) begin
            req_data.rom_addr = {bank, a[12:0]};
        end else begin
            req_data.rom_addr = {2'b10, a};
        end
    end

endmodule

// ==== hdl/io_ports.sv ====
/*
 * Cabinet I/O page
 * Player, coin, start, service and DIP switch read ports
 * Control register with init, rmrd and work bits
 * Sound latch and the sound CPU interrupt
 */
`timescale 1ns/1ns

module io_ports (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            io_rd,
    input  logic                            io_wr,
    input  logic [3:0]                      ofs,
    input  logic [main_bus_pkg::data_w-1:0] wdata,
    input  logic                            snd_ack,
    input  logic [1:0]                      start_button,
    input  logic [1:0]                      coin_input,
    input  logic [5:0]                      joystick1,
    input  logic [5:0]                      joystick2,
    input  logic                            service,
    input  logic [19:0]                     dipsw,
    output logic [main_bus_pkg::data_w-1:0] port_data,
    output logic                            work,
    output logic                            rmrd,
    output logic                            init,
    output logic                            snd_irq,
    output logic [main_bus_pkg::data_w-1:0] snd_latch
);
    import main_bus_pkg::*;

    logic [data_w-1:0] port_sel;
    logic [data_w-1:0] port_q;

    // Read port mux
    always_comb begin
        case (ofs)
            io_dip_hi_ofs:  port_sel = {3'b111, service, dipsw[19:16]};
            io_p1_ofs:      port_sel = {start_button[0], coin_input[0], joystick1};
            io_p2_ofs:      port_sel = {start_button[1], coin_input[1], joystick2};
            io_dip_mid_ofs: port_sel = dipsw[15:8];
            io_dip_lo_ofs:  port_sel = dipsw[7:0];
            // Watchdog and gaps read as open bus
            default:        port_sel = {data_w{1'b1}};
        endcase
    end

    // Last port byte read
    always_ff @(posedge clk) begin
        if (io_rd) begin
            port_q <= port_sel;
        end
    end

    // Fresh byte during the read cycle, held value after it
    assign port_data = io_rd ? port_sel : port_q;

    // Control register, bits 1:0 are coin counters and not kept
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            init <= 1'b0;
            rmrd <= 1'b0;
            work <= 1'b0;
        end else if (io_wr && ofs == io_ctrl_ofs) begin
            {init, rmrd, work} <= wdata[7:5];
        end
    end

    // Sound latch; a new latch write beats the acknowledge
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            snd_latch <= '0;
            snd_irq   <= 1'b0;
        end else if (io_wr && ofs == io_snd_ofs) begin
            snd_latch <= wdata;
            snd_irq   <= 1'b1;
        end else if (snd_ack) begin
            snd_irq <= 1'b0;
        end
    end

endmodule

// ==== hdl/read_return.sv ====
/*
 * Stage 2 access and return
 * Device strobes from the held request
 * ROM wait with stall of stage 1
 * Read data priority mux and response for the ack stage
 */
`timescale 1ns/1ns

module read_return (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                req_valid,
    input  main_bus_pkg::bus_req_t              req_data,
    input  logic [main_bus_pkg::data_w-1:0]     rom_data,
    input  logic                                rom_ok,
    input  logic [main_bus_pkg::data_w-1:0]     ram_dout,
    input  logic [main_bus_pkg::data_w-1:0]     pal_dout,
    input  logic [main_bus_pkg::data_w-1:0]     tile_dout,
    input  logic [main_bus_pkg::data_w-1:0]     obj_dout,
    input  logic [main_bus_pkg::data_w-1:0]     port_data,
    output logic                                stall,
    output logic                                rom_cs,
    output logic [main_bus_pkg::rom_addr_w-1:0] rom_addr,
    output logic                                ram_we,
    output logic                                pal_we,
    output logic                                tile_cs,
    output logic                                obj_cs,
    output logic                                io_rd,
    output logic                                io_wr,
    output logic                                rsp_valid,
    output main_bus_pkg::bus_rsp_t              rsp_data
);
    import main_bus_pkg::*;

    bus_sel_t          sel;
    logic              rom_ok_stale;
    logic [data_w-1:0] rdata;

    assign sel = req_data.sel;

    // ROM request held as long as stage 1 is stalled
    assign rom_cs   = req_valid && sel.rom;
    assign rom_addr = req_data.rom_addr;

    // On back-to-back ROM accesses rom_ok still belongs to the old address
    // for one cycle, so it is ignored then
    assign stall = rom_cs && (!rom_ok || rom_ok_stale);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rom_ok_stale <= 1'b0;
        end else begin
            rom_ok_stale <= rom_cs && !stall;
        end
    end

    // Single cycle strobes, no stall possible off the ROM
    assign ram_we  = req_valid && sel.ram && req_data.we;
    assign pal_we  = req_valid && sel.pal && req_data.we;
    assign tile_cs = req_valid && sel.tile;
    assign obj_cs  = req_valid && sel.obj;
    assign io_rd   = req_valid && sel.io && !req_data.we;
    assign io_wr   = req_valid && sel.io && req_data.we;

    // rom > ram > io > pal > tile > obj, open bus reads FF
    always_comb begin
        if (sel.rom) begin
            rdata = rom_data;
        end else if (sel.ram) begin
            rdata = ram_dout;
        end else if (sel.io) begin
            rdata = port_data;
        end else if (sel.pal) begin
            rdata = pal_dout;
        end else if (sel.tile) begin
            rdata = tile_dout;
        end else if (sel.obj) begin
            rdata = obj_dout;
        end else begin
            rdata = {data_w{1'b1}};
        end
    end

    // Writes get an ack too
    assign rsp_valid      = req_valid && !stall;
    assign rsp_data.rdata = rdata;
    assign rsp_data.we    = req_data.we;

endmodule

// ==== hdl/main_bus.sv ====
/*
 * Main CPU memory and I/O block, top level
 * Decode, stage 1 register, access and return, ack register
 * Cabinet I/O page with control register and sound latch
 */
`timescale 1ns/1ns

module main_bus (
    input  logic                                clk,
    input  logic                                rst,
    // CPU bus
    input  logic                                req,
    input  logic [main_bus_pkg::addr_w-1:0]     addr,
    input  logic                                we,
    input  logic [main_bus_pkg::data_w-1:0]     dout,
    output logic                                busy,
    output logic                                ack,
    output logic [main_bus_pkg::data_w-1:0]     din,
    // ROM
    output logic                                rom_cs,
    output logic [main_bus_pkg::rom_addr_w-1:0] rom_addr,
    input  logic [main_bus_pkg::data_w-1:0]     rom_data,
    input  logic                                rom_ok,
    // Work RAM and palette
    output logic                                ram_we,
    output logic                                pal_we,
    input  logic [main_bus_pkg::data_w-1:0]     ram_dout,
    input  logic [main_bus_pkg::data_w-1:0]     pal_dout,
    // Video
    output logic                                tile_cs,
    output logic                                obj_cs,
    output logic                                rmrd,
    input  logic [main_bus_pkg::data_w-1:0]     tile_dout,
    input  logic [main_bus_pkg::data_w-1:0]     obj_dout,
    // Sound
    output logic [main_bus_pkg::data_w-1:0]     snd_latch,
    output logic                                snd_irq,
    input  logic                                snd_ack,
    // Cabinet
    input  logic [1:0]                          start_button,
    input  logic [1:0]                          coin_input,
    input  logic [5:0]                          joystick1,
    input  logic [5:0]                          joystick2,
    input  logic                                service,
    input  logic [19:0]                         dipsw
);
    import main_bus_pkg::*;

    bus_req_t          dec_req;
    bus_req_t          dec_q;
    logic              dec_valid;
    bus_rsp_t          rsp_d;
    bus_rsp_t          rsp_q;
    logic              rsp_valid;
    logic              stall;
    logic              io_rd;
    logic              io_wr;
    logic [data_w-1:0] port_data;
    logic              work;
    logic              init;

    // Stage 1, decode
    addr_decode u_decode (
        .addr     ( addr     ),
        .we       ( we       ),
        .dout     ( dout     ),
        .work     ( work     ),
        .rmrd     ( rmrd     ),
        .init     ( init     ),
        .req_data ( dec_req  )
    );

    pipe_stage #(.payload_t(bus_req_t)) u_dec_stage (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .in_valid  ( req       ),
        .in_data   ( dec_req   ),
        .stall     ( stall     ),
        .out_valid ( dec_valid ),
        .out_data  ( dec_q     )
    );

    // Stage 2, access and return
    read_return u_return (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .req_valid ( dec_valid ),
        .req_data  ( dec_q     ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .ram_dout  ( ram_dout  ),
        .pal_dout  ( pal_dout  ),
        .tile_dout ( tile_dout ),
        .obj_dout  ( obj_dout  ),
        .port_data ( port_data ),
        .stall     ( stall     ),
        .rom_cs    ( rom_cs    ),
        .rom_addr  ( rom_addr  ),
        .ram_we    ( ram_we    ),
        .pal_we    ( pal_we    ),
        .tile_cs   ( tile_cs   ),
        .obj_cs    ( obj_cs    ),
        .io_rd     ( io_rd     ),
        .io_wr     ( io_wr     ),
        .rsp_valid ( rsp_valid ),
        .rsp_data  ( rsp_d     )
    );

    io_ports u_io (
        .clk          ( clk           ),
        .rst          ( rst           ),
        .io_rd        ( io_rd         ),
        .io_wr        ( io_wr         ),
        .ofs          ( dec_q.ofs     ),
        .wdata        ( dec_q.wdata   ),
        .snd_ack      ( snd_ack       ),
        .start_button ( start_button  ),
        .coin_input   ( coin_input    ),
        .joystick1    ( joystick1     ),
        .joystick2    ( joystick2     ),
        .service      ( service       ),
        .dipsw        ( dipsw         ),
        .port_data    ( port_data     ),
        .work         ( work          ),
        .rmrd         ( rmrd          ),
        .init         ( init          ),
        .snd_irq      ( snd_irq       ),
        .snd_latch    ( snd_latch     )
    );

    // Ack register, never stalled
    pipe_stage #(.payload_t(bus_rsp_t)) u_rsp_stage (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .in_valid  ( rsp_valid ),
        .in_data   ( rsp_d     ),
        .stall     ( 1'b0      ),
        .out_valid ( ack       ),
        .out_data  ( rsp_q     )
    );

    // Busy only while a ROM access waits
    assign busy = stall && dec_valid;
    assign din  = rsp_q.rdata;

endmodule

// ==== bench/main_bus_properties.sv ====
/*
 * Bus handshake and chip-select assertions, bound into main_bus
 * ack only with a request outstanding, no req while busy
 * ROM request held until rom_ok, one device strobe at a time
 */
`timescale 1ns/1ns

module main_bus_properties (
    input logic                                clk,
    input logic                                rst,
    input logic                                req,
    input logic                                busy,
    input logic                                ack,
    input logic                                rom_cs,
    input logic [main_bus_pkg::rom_addr_w-1:0] rom_addr,
    input logic                                rom_ok,
    input logic                                ram_we,
    input logic                                pal_we,
    input logic                                tile_cs,
    input logic                                obj_cs
);

    // Requests still waiting for their ack
    int pending;
    // Failed assertions so far
    int fail_count = 0;

    always @(posedge clk, posedge rst) begin
        if (rst) begin
            pending <= 0;
        end else begin
            pending <= pending + int'(req) - int'(ack);
        end
    end

    ack_after_req: assert property (@(posedge clk) disable iff (rst) ack |-> pending > 0)
        else begin
            $error("ack without an outstanding req");
            fail_count++;
        end

    no_req_when_busy: assert property (@(posedge clk) disable iff (rst) req |-> !busy)
        else begin
            $error("req while busy");
            fail_count++;
        end

    // Address must not move under a waiting ROM
    rom_held: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else begin
            $error("ROM request dropped or changed before rom_ok");
            fail_count++;
        end

    one_strobe: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, ram_we, pal_we, tile_cs, obj_cs}))
        else begin
            $error("more than one device strobe active");
            fail_count++;
        end

endmodule

bind main_bus main_bus_properties u_props (
    .clk      ( clk      ),
    .rst      ( rst      ),
    .req      ( req      ),
    .busy     ( busy     ),
    .ack      ( ack      ),
    .rom_cs   ( rom_cs   ),
    .rom_addr ( rom_addr ),
    .rom_ok   ( rom_ok   ),
    .ram_we   ( ram_we   ),
    .pal_we   ( pal_we   ),
    .tile_cs  ( tile_cs  ),
    .obj_cs   ( obj_cs   )
);

// ==== bench/main_bus_tb.sv ====
/*
 * Testbench for the main CPU memory and I/O block
 * Acts as the CPU and applies a stimulus table over the bus
 * ROM model with LCG data and a random rom_ok delay
 * Compare tasks, sound latch handshake and the closing report
 */
`timescale 1ns/1ns

module main_bus_tb;
    import main_bus_pkg::*;

    // One table row with strobes as {rom_cs, ram_we, pal_we, tile_cs, obj_cs}
    typedef struct packed {
        logic [addr_w-1:0]     addr;
        logic                  we;
        logic [data_w-1:0]     data;
        logic [4:0]            strobes;
        logic [rom_addr_w-1:0] rom_addr;
        logic [data_w-1:0]     rdata;
    } test_t;

    localparam int ack_timeout = 20;

    logic                  clk;
    logic                  rst;
    logic                  req;
    logic [addr_w-1:0]     addr;
    logic                  we;
    logic [data_w-1:0]     dout;
    logic                  busy;
    logic                  ack;
    logic [data_w-1:0]     din;
    logic                  rom_cs;
    logic [rom_addr_w-1:0] rom_addr;
    logic [data_w-1:0]     rom_data;
    logic                  rom_ok;
    logic                  ram_we;
    logic                  pal_we;
    logic [data_w-1:0]     ram_dout;
    logic [data_w-1:0]     pal_dout;
    logic                  tile_cs;
    logic                  obj_cs;
    logic                  rmrd;
    logic [data_w-1:0]     tile_dout;
    logic [data_w-1:0]     obj_dout;
    logic [data_w-1:0]     snd_latch;
    logic                  snd_irq;
    logic                  snd_ack;
    logic [1:0]            start_button;
    logic [1:0]            coin_input;
    logic [5:0]            joystick1;
    logic [5:0]            joystick2;
    logic                  service;
    logic [19:0]           dipsw;

    test_t             tests[$];
    logic [31:0]       seed;
    logic [data_w-1:0] rom_byte;
    int                rom_delay;
    int                rom_wait;
    int                checks;
    int                errors;
    int                tests_run;
    logic              timed_out;
    // rmrd as last written to the control register
    logic              exp_rmrd;

    main_bus uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ROM answers after rom_delay cycles of rom_cs
    always @(posedge clk) begin
        if (!rom_cs) begin
            rom_ok   <= 1'b0;
            rom_wait <= rom_delay;
        end else if (!rom_ok) begin
            if (rom_wait == 0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_byte;
            end else begin
                rom_wait <= rom_wait - 1;
            end
        end
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic bus_sel_t to_sel(input logic [4:0] s);
        bus_sel_t r;
        r = '0;
        {r.rom, r.ram, r.pal, r.tile, r.obj} = s;
        return r;
    endfunction

    function automatic bus_sel_t strobe_sel();
        return to_sel({rom_cs, ram_we, pal_we, tile_cs, obj_cs});
    endfunction

    function automatic void note_fail(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endfunction

    task automatic check_rsp(input string what, input bus_rsp_t got, input bus_rsp_t exp);
        checks++;
        // Write acks carry no meaningful read data
        if (got.we !== exp.we || (!exp.we && got.rdata !== exp.rdata)) begin
            note_fail($sformatf("%s rsp %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_sel(input string what, input bus_sel_t got, input bus_sel_t exp);
        checks++;
        if (got !== exp) begin
            note_fail($sformatf("%s strobes %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_rom(input string what, input logic [rom_addr_w-1:0] got,
                             input logic [rom_addr_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            note_fail($sformatf("%s rom_addr %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_byte(input string what, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
        checks++;
        if (got !== exp) begin
            note_fail($sformatf("%s %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            note_fail($sformatf("%s %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_lat(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            note_fail($sformatf("%s latency %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic note_timeout(input string why);
        errors++;
        timed_out = 1'b1;
        $display("Timeout: %s at %0t ns", why, $time);
    endtask

    task automatic add_test(input logic [addr_w-1:0] a, input logic w,
                            input logic [data_w-1:0] d, input logic [4:0] s,
                            input logic [rom_addr_w-1:0] ra, input logic [data_w-1:0] rd);
        test_t t;
        t = '{addr: a, we: w, data: d, strobes: s, rom_addr: ra, rdata: rd};
        tests.push_back(t);
    endtask

    task automatic fill_table();
        // Fixed ROM ignores the bank byte
        add_test(24'h00_8000, 1'b0, 8'h00, 5'b10000, 18'h28000, 8'h00);
        add_test(24'h00_ffff, 1'b0, 8'h00, 5'b10000, 18'h2ffff, 8'h00);
        add_test(24'h7e_9abc, 1'b0, 8'h00, 5'b10000, 18'h29abc, 8'h00);
        add_test(24'h00_c123, 1'b0, 8'h00, 5'b10000, 18'h2c123, 8'h00);
        // Banked window
        add_test(24'h03_2000, 1'b0, 8'h00, 5'b10000, 18'h06000, 8'h00);
        add_test(24'h1f_3fff, 1'b0, 8'h00, 5'b10000, 18'h3ffff, 8'h00);
        add_test(24'ha5_2345, 1'b0, 8'h00, 5'b10000, 18'h0a345, 8'h00);
        // RAM in the low 1kB with work clear and palette with work set
        add_test(24'h00_0100, 1'b1, 8'h11, 5'b01000, 18'h0, 8'h00);
        add_test(24'h00_0100, 1'b0, 8'h00, 5'b00000, 18'h0, 8'h5a);
        add_test(24'h00_5f88, 1'b1, 8'h20, 5'b00000, 18'h0, 8'h00);
        add_test(24'h00_0100, 1'b1, 8'h22, 5'b00100, 18'h0, 8'h00);
        add_test(24'h00_0100, 1'b0, 8'h00, 5'b00000, 18'h0, 8'ha5);
        add_test(24'h00_0400, 1'b0, 8'h00, 5'b00000, 18'h0, 8'h5a);
        add_test(24'h00_5f88, 1'b1, 8'h00, 5'b00000, 18'h0, 8'h00);
        add_test(24'h00_0100, 1'b0, 8'h00, 5'b00000, 18'h0, 8'h5a);
        // Cabinet ports and two gap offsets
        add_test(24'h00_5f80, 1'b0, 8'h00, 5'b00000, 18'h0, 8'hfa);
        add_test(24'h00_5f81, 1'b0, 8'h00, 5'b00000, 18'h0, 8'h55);
        add_test(24'h00_5f82, 1'b0, 8'h00, 5'b00000, 18'h0, 8'haa);
        add_test(24'h00_5f83, 1'b0, 8'h00, 5'b00000, 18'h0, 8'h5c);
        add_test(24'h00_5f84, 1'b0, 8'h00, 5'b00000, 18'h0, 8'h3e);
        add_test(24'h00_5f85, 1'b0, 8'h00, 5'b00000, 18'h0, 8'hff);
        add_test(24'h00_5f9f, 1'b0, 8'h00, 5'b00000, 18'h0, 8'hff);
        // Object area against init and rmrd
        add_test(24'h00_7c00, 1'b0, 8'h00, 5'b00010, 18'h0, 8'h3c);
        add_test(24'h00_5f88, 1'b1, 8'h80, 5'b00000, 18'h0, 8'h00);
        add_test(24'h00_7c00, 1'b0, 8'h00, 5'b00001, 18'h0, 8'hc3);
        add_test(24'h00_7800, 1'b0, 8'h00, 5'b00001, 18'h0, 8'hc3);
        add_test(24'h00_7808, 1'b0, 8'h00, 5'b00010, 18'h0, 8'h3c);
        add_test(24'h00_5f88, 1'b1, 8'hc0, 5'b00000, 18'h0, 8'h00);
        add_test(24'h00_7c00, 1'b0, 8'h00, 5'b00010, 18'h0, 8'h3c);
        add_test(24'h00_5f88, 1'b1, 8'h00, 5'b00000, 18'h0, 8'h00);
        // Sound latch write with the irq checked afterwards
        add_test(24'h00_5f8c, 1'b1, 8'h77, 5'b00000, 18'h0, 8'h00);
    endtask

    task automatic run_test(input int idx);
        test_t             t;
        bus_sel_t          got_sel;
        bus_rsp_t          got_rsp;
        bus_rsp_t          exp_rsp;
        logic [rom_addr_w-1:0] got_rom;
        logic [31:0]       r;
        logic              busy_seen;
        logic              done;
        int                lat;
        int                guard;
        t         = tests[idx];
        got_sel   = '0;
        got_rsp   = '0;
        got_rom   = '0;
        busy_seen = 1'b0;
        done      = 1'b0;
        lat       = 1;
        guard     = 0;
        r         = lcg_next();
        rom_byte  = r[31:24];
        rom_delay = int'(r[18:16]) % 6;
        // Bus must be idle before a new request
        @(negedge clk);
        while (busy && guard < ack_timeout) begin
            @(negedge clk);
            guard++;
        end
        if (busy) begin
            note_timeout($sformatf("busy stuck before test %0d", idx));
            return;
        end
        @(posedge clk);
        req  <= 1'b1;
        addr <= t.addr;
        we   <= t.we;
        dout <= t.data;
        @(posedge clk);
        req <= 1'b0;
        while (!done && lat <= ack_timeout) begin
            @(negedge clk);
            got_sel   = got_sel | strobe_sel();
            busy_seen = busy_seen | busy;
            if (rom_cs) begin
                got_rom = rom_addr;
            end
            if (ack) begin
                done          = 1'b1;
                got_rsp.rdata = din;
                got_rsp.we    = uut.rsp_q.we;
            end else begin
                @(posedge clk);
                lat++;
            end
        end
        if (!done) begin
            note_timeout($sformatf("no ack for test %0d", idx));
        end else begin
            check_sel($sformatf("test %0d", idx), got_sel, to_sel(t.strobes));
            if (t.strobes[4]) begin
                check_rom($sformatf("test %0d", idx), got_rom, t.rom_addr);
                // ROM always waits at least one cycle
                check_flag($sformatf("test %0d busy", idx), busy_seen, 1'b1);
                exp_rsp.rdata = rom_byte;
            end else begin
                // Fixed two-cycle path that never goes busy
                check_lat($sformatf("test %0d", idx), lat, 2);
                check_flag($sformatf("test %0d busy", idx), busy_seen, 1'b0);
                exp_rsp.rdata = t.rdata;
            end
            exp_rsp.we = t.we;
            check_rsp($sformatf("test %0d", idx), got_rsp, exp_rsp);
            // Control register holds rmrd in data bit 6
            if (t.we && t.addr[15:0] == 16'h5f88) begin
                exp_rmrd = t.data[6];
            end
            check_flag($sformatf("test %0d rmrd", idx), rmrd, exp_rmrd);
            tests_run++;
            $display("test %0d addr %h we %0d acked after %0d cycles", idx, t.addr, t.we, lat);
        end
    endtask

    task automatic sound_test();
        check_byte("snd_latch", snd_latch, 8'h77);
        check_flag("snd_irq set", snd_irq, 1'b1);
        // irq holds with no acknowledge
        repeat (3) @(negedge clk);
        check_flag("snd_irq held", snd_irq, 1'b1);
        @(posedge clk);
        snd_ack <= 1'b1;
        @(posedge clk);
        snd_ack <= 1'b0;
        @(negedge clk);
        check_flag("snd_irq cleared", snd_irq, 1'b0);
        tests_run++;
        $display("sound latch handshake done");
    endtask

    initial begin
        seed         = 32'h5fa6;
        rst          = 1'b1;
        req          = 1'b0;
        addr         = '0;
        we           = 1'b0;
        dout         = '0;
        rom_data     = '0;
        rom_ok       = 1'b0;
        ram_dout     = 8'h5a;
        pal_dout     = 8'ha5;
        tile_dout    = 8'h3c;
        obj_dout     = 8'hc3;
        snd_ack      = 1'b0;
        start_button = 2'b10;
        coin_input   = 2'b01;
        joystick1    = 6'h15;
        joystick2    = 6'h2a;
        service      = 1'b1;
        dipsw        = 20'ha5c3e;
        rom_delay    = 0;
        rom_wait     = 0;
        checks       = 0;
        errors       = 0;
        tests_run    = 0;
        timed_out    = 1'b0;
        exp_rmrd     = 1'b0;
        fill_table();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        // Idle state right after reset
        @(negedge clk);
        check_sel("reset", strobe_sel(), '0);
        check_flag("reset ack", ack, 1'b0);
        check_flag("reset busy", busy, 1'b0);
        check_flag("reset snd_irq", snd_irq, 1'b0);
        check_flag("reset rmrd", rmrd, 1'b0);
        check_byte("reset snd_latch", snd_latch, 8'h00);
        tests_run++;
        $display("reset state done");
        for (int i = 0; i < tests.size() && !timed_out; i++) begin
            run_test(i);
        end
        if (!timed_out) begin
            sound_test();
        end
        errors += uut.u_props.fail_count;
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hdl/main_bus_pkg.sv
hdl/pipe_stage.sv
hdl/addr_decode.sv
hdl/io_ports.sv
hdl/read_return.sv
hdl/main_bus.sv
bench/main_bus_properties.sv
bench/main_bus_tb.sv
